// ==== disp_pkg.sv ====
/* tiny simulation video mode, far below what a real monitor accepts
   canvas, window and timing are fixed here for the whole design; sync pulses are active high */
package disp_pkg;

    typedef logic signed [15:0] coord_t;  // screen coordinate
    typedef logic [5:0] canv_addr_t;      // row-major canvas address
    typedef logic [3:0] canv_pix_t;       // palette index
    typedef logic [14:0] colr_t;          // RGB555, red in the top bits
    typedef logic [7:0] chan_t;           // one widened colour channel
    typedef logic [9:0] tmds_sym_t;       // one TMDS symbol

    // horizontal timing in pixels
    localparam coord_t H_ACTIVE = 16'sd40;
    localparam coord_t H_FRONT = 16'sd4;
    localparam coord_t H_SYNC = 16'sd6;
    localparam coord_t H_BACK = 16'sd6;
    localparam coord_t H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 56
    localparam coord_t H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam coord_t H_SYNC_END = H_SYNC_START + H_SYNC - 16'sd1;  // inclusive

    // vertical timing in lines
    localparam coord_t V_ACTIVE = 16'sd24;
    localparam coord_t V_FRONT = 16'sd2;
    localparam coord_t V_SYNC = 16'sd2;
    localparam coord_t V_BACK = 16'sd3;
    localparam coord_t V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 31
    localparam coord_t V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam coord_t V_SYNC_END = V_SYNC_START + V_SYNC - 16'sd1;

    // canvas and the window it is shown in
    localparam coord_t CANV_WIDTH = 16'sd8;
    localparam coord_t CANV_HEIGHT = 16'sd5;
    localparam coord_t CANV_SCALE = 16'sd4;    // screen pixels per canvas pixel
    localparam int CANV_PIXELS = int'(CANV_WIDTH * CANV_HEIGHT);
    localparam int COL_W = $clog2(CANV_WIDTH);   // canvas column counter
    localparam int ROW_W = $clog2(CANV_HEIGHT);  // canvas row counter
    localparam int SUB_W = $clog2(CANV_SCALE);   // steps inside one canvas pixel
    localparam coord_t WIN_STARTX = 16'sd4;
    localparam coord_t WIN_STARTY = 16'sd2;
    localparam coord_t WIN_ENDX = WIN_STARTX + CANV_WIDTH * CANV_SCALE;   // exclusive
    localparam coord_t WIN_ENDY = WIN_STARTY + CANV_HEIGHT * CANV_SCALE;  // exclusive

    localparam colr_t BG_COLR = 15'h0886;  // shown outside the window
    localparam int PAL_DEPTH = 16;

    // DVI control tokens, indexed by {c1, c0}
    localparam tmds_sym_t TMDS_CTRL_00 = 10'b1101010100;
    localparam tmds_sym_t TMDS_CTRL_01 = 10'b0010101011;
    localparam tmds_sym_t TMDS_CTRL_10 = 10'b0101010100;
    localparam tmds_sym_t TMDS_CTRL_11 = 10'b1010101011;

endpackage

// ==== display_timings.sv ====
/* outputs are one clock behind the internal counters, so the first position
   after reset is (0,0) with frame high; all flags are low while reset is held */
module display_timings (
    input  logic clk_pix,
    input  logic reset,
    output disp_pkg::coord_t sx,  // screen x of the current pixel
    output disp_pkg::coord_t sy,  // screen y
    output logic hsync,
    output logic vsync,
    output logic de,              // active video
    output logic frame            // one clock at (0,0)
);
    import disp_pkg::*;

    coord_t h_cnt, v_cnt;  // free-running scan position

    // line and frame counters
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_TOTAL - 16'sd1) begin
            h_cnt <= '0;
            if (v_cnt == V_TOTAL - 16'sd1) begin
                v_cnt <= '0;  // wrap to next frame
            end else begin
                v_cnt <= v_cnt + 16'sd1;
            end
        end else begin
            h_cnt <= h_cnt + 16'sd1;
        end
    end

    // decode the count into position and flags, all in one register stage
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= '0;
            sy <= '0;
            hsync <= 1'b0;
            vsync <= 1'b0;
            de <= 1'b0;
            frame <= 1'b0;
        end else begin
            sx <= h_cnt;
            sy <= v_cnt;
            hsync <= (h_cnt >= H_SYNC_START) && (h_cnt <= H_SYNC_END);
            vsync <= (v_cnt >= V_SYNC_START) && (v_cnt <= V_SYNC_END);  // whole lines
            de <= (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
            frame <= (h_cnt == '0) && (v_cnt == '0);
        end
    end

endmodule

// ==== canvas_window.sv ====
/* expects sx to step by one each clock and sy by one each line, as display_timings does
   the read address is forced to 0 outside the window */
module canvas_window (
    input  logic clk_pix,
    input  logic reset,
    input  disp_pkg::coord_t sx,
    input  disp_pkg::coord_t sy,
    output disp_pkg::canv_addr_t canv_rd_addr,  // valid one clock after sx/sy
    output logic in_win
);
    import disp_pkg::*;

    logic [COL_W-1:0] col_q, cur_col;    // canvas column
    logic [SUB_W-1:0] subx_q, cur_subx;  // screen pixels into that column
    logic [ROW_W-1:0] row_q, cur_row;    // canvas row
    logic [SUB_W-1:0] suby_q, cur_suby;  // screen lines into that row
    logic in_x, in_y;

    always_comb begin
        in_x = (sx >= WIN_STARTX) && (sx < WIN_ENDX);
        in_y = (sy >= WIN_STARTY) && (sy < WIN_ENDY);
        // window edges restart the counts so nothing carries over between lines or frames
        cur_col = (sx == WIN_STARTX) ? '0 : col_q;
        cur_subx = (sx == WIN_STARTX) ? '0 : subx_q;
        cur_row = (sy == WIN_STARTY) ? '0 : row_q;
        cur_suby = (sy == WIN_STARTY) ? '0 : suby_q;
    end

    // column steps every CANV_SCALE pixels, row every CANV_SCALE lines, no divider needed
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            col_q <= '0;
            subx_q <= '0;
            row_q <= '0;
            suby_q <= '0;
        end else begin
            if (in_x) begin
                if (cur_subx == SUB_W'(CANV_SCALE - 16'sd1)) begin
                    subx_q <= '0;
                    col_q <= cur_col + COL_W'(1);
                end else begin
                    subx_q <= cur_subx + SUB_W'(1);
                    col_q <= cur_col;
                end
            end
            if (in_y && sx == H_TOTAL - 16'sd1) begin  // last pixel of the line
                if (cur_suby == SUB_W'(CANV_SCALE - 16'sd1)) begin
                    suby_q <= '0;
                    row_q <= cur_row + ROW_W'(1);
                end else begin
                    suby_q <= cur_suby + SUB_W'(1);
                    row_q <= cur_row;
                end
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            in_win <= 1'b0;
        end else begin
            in_win <= in_x && in_y;
        end
        if (in_x && in_y) begin
            canv_rd_addr <= canv_addr_t'(cur_row) * canv_addr_t'(CANV_WIDTH)
                          + canv_addr_t'(cur_col);  // row-major
        end else begin
            canv_rd_addr <= '0;
        end
    end

endmodule

// ==== canvas_buffer.sv ====
/* write addresses beyond the canvas size are not stored
   a read in the same clock as a write to that address returns the old pixel */
module canvas_buffer (
    input  logic clk_pix,
    input  logic canv_we,                       // single-clock write strobe
    input  disp_pkg::canv_addr_t canv_wr_addr,
    input  disp_pkg::canv_pix_t canv_wr_pix,
    input  disp_pkg::canv_addr_t canv_rd_addr,
    output disp_pkg::canv_pix_t canv_rd_pix     // one clock after the address
);
    import disp_pkg::*;

    canv_pix_t mem [CANV_PIXELS];  // 4 bits per pixel, row-major

    // simple dual port, one write and one read each clock
    always_ff @(posedge clk_pix) begin
        if (canv_we && int'(canv_wr_addr) < CANV_PIXELS) begin
            mem[canv_wr_addr] <= canv_wr_pix;
        end
        canv_rd_pix <= mem[canv_rd_addr];  // read-before-write
    end

endmodule

// ==== colour_stage.sv ====
/* control inputs are expected straight from display_timings, two clocks ahead of canv_rd_pix
   a palette write to the index being read shows in the same output; frame_o is one clock later */
module colour_stage (
    input  logic clk_pix,
    input  logic reset,
    input  logic hsync,
    input  logic vsync,
    input  logic de,
    input  logic frame,
    input  logic in_win,                       // one clock ahead of canv_rd_pix
    input  disp_pkg::canv_pix_t canv_rd_pix,
    input  logic pal_we,                       // palette write strobe
    input  disp_pkg::canv_pix_t pal_wr_addr,
    input  disp_pkg::colr_t pal_wr_colr,
    output disp_pkg::chan_t red,
    output disp_pkg::chan_t green,
    output disp_pkg::chan_t blue,
    output logic hsync_o,
    output logic vsync_o,
    output logic de_o,
    output logic frame_o                       // lines up with the encoder symbols
);
    import disp_pkg::*;

    colr_t pal [PAL_DEPTH];                       // RGB555 palette
    logic [1:0] hsync_d, vsync_d, de_d, frame_d;  // two-stage alignment
    logic in_win_d;
    logic frame_a;                                // frame at colour output time
    colr_t colr;

    // 5 to 8 bits, top bits repeated so full scale stays full scale
    function automatic chan_t widen(input logic [4:0] c);
        return {c, c[4:2]};
    endfunction

    always_ff @(posedge clk_pix) begin
        if (pal_we) begin
            pal[pal_wr_addr] <= pal_wr_colr;
        end
    end

    always_comb begin
        if (!in_win_d) begin
            colr = BG_COLR;
        end else if (pal_we && pal_wr_addr == canv_rd_pix) begin
            colr = pal_wr_colr;  // bypass the entry being written
        end else begin
            colr = pal[canv_rd_pix];
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            hsync_d <= '0;
            vsync_d <= '0;
            de_d <= '0;
            frame_d <= '0;
            in_win_d <= 1'b0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            de_o <= 1'b0;
            frame_a <= 1'b0;
            frame_o <= 1'b0;
        end else begin
            hsync_d <= {hsync_d[0], hsync};
            vsync_d <= {vsync_d[0], vsync};
            de_d <= {de_d[0], de};
            frame_d <= {frame_d[0], frame};
            in_win_d <= in_win;  // window is one stage behind the timings already
            hsync_o <= hsync_d[1];
            vsync_o <= vsync_d[1];
            de_o <= de_d[1];
            frame_a <= frame_d[1];
            frame_o <= frame_a;  // extra stage for the TMDS register
        end
    end

    always_ff @(posedge clk_pix) begin
        red <= widen(colr[14:10]);
        green <= widen(colr[9:5]);
        blue <= widen(colr[4:0]);
    end

endmodule

// ==== tmds_encoder.sv ====
/* one DVI channel, symbol registered one clock after its inputs
   running disparity is cleared whenever de is low */
module tmds_encoder (
    input  logic clk_pix,
    input  logic reset,
    input  disp_pkg::chan_t din,     // pixel data while de is high
    input  logic [1:0] ctrl,         // {c1, c0} sent during blanking
    input  logic de,
    output disp_pkg::tmds_sym_t sym
);
    import disp_pkg::*;

    logic [3:0] n1_d;              // ones in din
    logic [3:0] n1_q;              // ones in q_m[7:0]
    logic use_xnor;
    logic [8:0] q_m;               // transition-minimised word
    logic signed [5:0] bal;        // ones minus zeros in q_m[7:0]
    logic signed [5:0] cnt;        // running disparity
    logic signed [5:0] cnt_next;
    tmds_sym_t sym_next;

    // stage 1 of the algorithm, XOR or XNOR chain
    always_comb begin
        n1_d = '0;
        for (int i = 0; i < 8; i++) begin
            n1_d = n1_d + 4'(din[i]);
        end
        use_xnor = (n1_d > 4'd4) || (n1_d == 4'd4 && !din[0]);
        q_m[0] = din[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ din[i]) : (q_m[i-1] ^ din[i]);
        end
        q_m[8] = !use_xnor;  // tells the receiver which chain was used
        n1_q = '0;
        for (int i = 0; i < 8; i++) begin
            n1_q = n1_q + 4'(q_m[i]);
        end
        bal = $signed({1'b0, n1_q, 1'b0}) - 6'sd8;
    end

    // stage 2, invert or not to pull the disparity back towards zero
    always_comb begin
        if (cnt == '0 || bal == '0) begin
            sym_next = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            cnt_next = q_m[8] ? cnt + bal : cnt - bal;
        end else if ((cnt > 6'sd0 && bal > 6'sd0) || (cnt < 6'sd0 && bal < 6'sd0)) begin
            sym_next = {1'b1, q_m[8], ~q_m[7:0]};  // inverted
            cnt_next = cnt + (q_m[8] ? 6'sd2 : 6'sd0) - bal;
        end else begin
            sym_next = {1'b0, q_m[8], q_m[7:0]};
            cnt_next = cnt - (q_m[8] ? 6'sd0 : 6'sd2) + bal;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sym <= TMDS_CTRL_00;
            cnt <= '0;
        end else if (de) begin
            sym <= sym_next;
            cnt <= cnt_next;
        end else begin
            cnt <= '0;  // blanking restarts the balance
            case (ctrl)
                2'b00: sym <= TMDS_CTRL_00;
                2'b01: sym <= TMDS_CTRL_01;
                2'b10: sym <= TMDS_CTRL_10;
                default: sym <= TMDS_CTRL_11;
            endcase
        end
    end

endmodule

// ==== display_top.sv ====
/* parallel 10-bit symbols only, serializer and clock channel live outside
   a pixel's symbols appear 5 clocks after the timing counters reach it */
module display_top (
    input  logic clk_pix,
    input  logic reset,
    input  logic canv_we,
    input  disp_pkg::canv_addr_t canv_wr_addr,
    input  disp_pkg::canv_pix_t canv_wr_pix,
    input  logic pal_we,
    input  disp_pkg::canv_pix_t pal_wr_addr,
    input  disp_pkg::colr_t pal_wr_colr,
    output disp_pkg::tmds_sym_t tmds_ch0,  // blue with sync
    output disp_pkg::tmds_sym_t tmds_ch1,  // green
    output disp_pkg::tmds_sym_t tmds_ch2,  // red
    output logic frame_out                 // with the first active symbols
);
    import disp_pkg::*;

    coord_t sx, sy;
    logic hsync, vsync, de, frame;           // from the timing generator
    canv_addr_t canv_rd_addr;
    logic in_win;
    canv_pix_t canv_rd_pix;
    chan_t red, green, blue;
    logic disp_hsync, disp_vsync, disp_de;   // aligned with the colour

    display_timings i_display_timings (
        .clk_pix(clk_pix), .reset(reset),
        .sx(sx), .sy(sy), .hsync(hsync), .vsync(vsync), .de(de), .frame(frame)
    );

    canvas_window i_canvas_window (
        .clk_pix(clk_pix), .reset(reset), .sx(sx), .sy(sy),
        .canv_rd_addr(canv_rd_addr), .in_win(in_win)
    );

    canvas_buffer i_canvas_buffer (
        .clk_pix(clk_pix), .canv_we(canv_we), .canv_wr_addr(canv_wr_addr),
        .canv_wr_pix(canv_wr_pix), .canv_rd_addr(canv_rd_addr), .canv_rd_pix(canv_rd_pix)
    );

    colour_stage i_colour_stage (
        .clk_pix(clk_pix), .reset(reset),
        .hsync(hsync), .vsync(vsync), .de(de), .frame(frame), .in_win(in_win),
        .canv_rd_pix(canv_rd_pix),
        .pal_we(pal_we), .pal_wr_addr(pal_wr_addr), .pal_wr_colr(pal_wr_colr),
        .red(red), .green(green), .blue(blue),
        .hsync_o(disp_hsync), .vsync_o(disp_vsync), .de_o(disp_de), .frame_o(frame_out)
    );

    // sync rides on the blue channel as c0 = hsync, c1 = vsync
    tmds_encoder i_tmds_ch0 (
        .clk_pix(clk_pix), .reset(reset), .din(blue),
        .ctrl({disp_vsync, disp_hsync}), .de(disp_de), .sym(tmds_ch0)
    );

    tmds_encoder i_tmds_ch1 (
        .clk_pix(clk_pix), .reset(reset), .din(green),
        .ctrl(2'b00), .de(disp_de), .sym(tmds_ch1)
    );

    tmds_encoder i_tmds_ch2 (
        .clk_pix(clk_pix), .reset(reset), .din(red),
        .ctrl(2'b00), .de(disp_de), .sym(tmds_ch2)
    );

endmodule

// ==== tb_display.sv ====
/* relies on the fixed 5-clock latency from scan position to symbols
   frame 0 is used to load the memories, frames 1 to 3 are checked pixel by pixel */
module tb_display;
    timeunit 1ns;
    timeprecision 100ps;
    import disp_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int PIPE_CYC = 5;  // scan position to symbols
    localparam int LINE_CYC = int'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK);
    localparam int FRAME_CYC = LINE_CYC * int'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
    localparam int HS_LO = int'(H_ACTIVE + H_FRONT);  // first hsync pixel
    localparam int HS_HI = HS_LO + int'(H_SYNC);      // first pixel after the pulse
    localparam int VS_LO = int'(V_ACTIVE + V_FRONT);
    localparam int VS_HI = VS_LO + int'(V_SYNC);
    localparam int CW = int'(CANV_WIDTH);
    localparam int CH = int'(CANV_HEIGHT);
    localparam int CS = int'(CANV_SCALE);
    localparam int WX0 = int'(WIN_STARTX);
    localparam int WY0 = int'(WIN_STARTY);
    localparam int WATCHDOG_NS = (4 * FRAME_CYC + 200) * CLK_PERIOD;  // four frames and slack
    localparam tmds_sym_t TOKEN_00 = 10'b1101010100;  // both control bits low

    logic clk_pix = 1'b0;
    logic reset;
    logic canv_we;
    canv_addr_t canv_wr_addr;
    canv_pix_t canv_wr_pix;
    logic pal_we;
    canv_pix_t pal_wr_addr;
    colr_t pal_wr_colr;
    tmds_sym_t tmds_ch0, tmds_ch1, tmds_ch2;
    logic frame_out;

    int seed = 30011;
    int cycles;                            // clocks since reset was released
    int disp [3];                          // running disparity per channel
    colr_t pal_model [PAL_DEPTH];          // what the palette should hold
    canv_pix_t canv_model [CANV_PIXELS];   // what the canvas should hold

    display_top i_display_top (
        .clk_pix(clk_pix), .reset(reset),
        .canv_we(canv_we), .canv_wr_addr(canv_wr_addr), .canv_wr_pix(canv_wr_pix),
        .pal_we(pal_we), .pal_wr_addr(pal_wr_addr), .pal_wr_colr(pal_wr_colr),
        .tmds_ch0(tmds_ch0), .tmds_ch1(tmds_ch1), .tmds_ch2(tmds_ch2), .frame_out(frame_out)
    );

    always #(CLK_PERIOD / 2) clk_pix = ~clk_pix;

    always @(posedge clk_pix) begin
        if (reset) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first error");
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired, the tests did not finish in time");
    end

    task automatic check_colr(input string name, input colr_t got, input colr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail time=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_chan(input string name, input chan_t got, input chan_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail time=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_sym(input string name, input tmds_sym_t got, input tmds_sym_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail time=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail time=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // {is token, c1, c0}, standard DVI control tokens
    function automatic logic [2:0] ctrl_decode(input tmds_sym_t s);
        case (s)
            10'b1101010100: return 3'b100;
            10'b0010101011: return 3'b101;
            10'b0101010100: return 3'b110;
            10'b1010101011: return 3'b111;
            default: return 3'b000;
        endcase
    endfunction

    // receiver side of the 8b/10b data path
    function automatic chan_t data_decode(input tmds_sym_t s);
        logic [7:0] q;
        chan_t d;
        q = s[9] ? ~s[7:0] : s[7:0];  // undo the inversion
        d[0] = q[0];
        for (int i = 1; i < 8; i++) begin
            d[i] = s[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);  // bit 8 high means XOR chain
        end
        return d;
    endfunction

    function automatic colr_t expected_colr(input int x, input int y);
        int cx, cy;
        if (x >= WX0 && x < WX0 + CW * CS && y >= WY0 && y < WY0 + CH * CS) begin
            cx = (x - WX0) / CS;
            cy = (y - WY0) / CS;
            return pal_model[canv_model[cy * CW + cx]];
        end
        return BG_COLR;  // outside the window
    endfunction

    // 5-bit channel shifted up by three with its top three bits below
    function automatic chan_t widened(input logic [4:0] c);
        return {c, 3'b000} | chan_t'(c >> 2);
    endfunction

    task automatic palette_write(input canv_pix_t idx, input colr_t c);
        pal_we = 1'b1;
        pal_wr_addr = idx;
        pal_wr_colr = c;
        pal_model[idx] = c;
        @(negedge clk_pix);
        pal_we = 1'b0;
    endtask

    task automatic canvas_write(input canv_addr_t addr, input canv_pix_t pix);
        canv_we = 1'b1;
        canv_wr_addr = addr;
        canv_wr_pix = pix;
        canv_model[addr] = pix;
        @(negedge clk_pix);
        canv_we = 1'b0;
    endtask

    task automatic expect_idle(input string when);
        check_sym({"tmds_ch0 ", when}, tmds_ch0, TOKEN_00);
        check_sym({"tmds_ch1 ", when}, tmds_ch1, TOKEN_00);
        check_sym({"tmds_ch2 ", when}, tmds_ch2, TOKEN_00);
        check_bit({"frame_out ", when}, frame_out, 1'b0);
    endtask

    // one screen position at the outputs, sampled on the falling edge
    task automatic verify_pixel(input int x, input int y);
        tmds_sym_t syms [3];
        chan_t chans [3];
        logic [2:0] tok;
        string where;
        colr_t want;
        where = $sformatf("at (%0d,%0d)", x, y);
        syms[0] = tmds_ch0;  // blue
        syms[1] = tmds_ch1;  // green
        syms[2] = tmds_ch2;  // red
        check_bit({"frame_out ", where}, frame_out, x == 0 && y == 0);
        if (x < int'(H_ACTIVE) && y < int'(V_ACTIVE)) begin
            for (int c = 0; c < 3; c++) begin
                tok = ctrl_decode(syms[c]);
                if (tok[2]) begin
                    abort_run($sformatf("channel %0d sent a control token in active video %s",
                                        c, where));
                end
                chans[c] = data_decode(syms[c]);
                disp[c] = disp[c] + 2 * $countones(syms[c]) - 10;  // ones minus zeros
                if (disp[c] > 10 || disp[c] < -10) begin
                    abort_run($sformatf("channel %0d running disparity %0d out of range %s",
                                        c, disp[c], where));
                end
            end
            want = expected_colr(x, y);
            check_colr({"pixel colour ", where},
                       {chans[2][7:3], chans[1][7:3], chans[0][7:3]}, want);
            // low bits of each channel come from the widening
            check_chan({"red ", where}, chans[2], widened(want[14:10]));
            check_chan({"green ", where}, chans[1], widened(want[9:5]));
            check_chan({"blue ", where}, chans[0], widened(want[4:0]));
        end else begin
            tok = ctrl_decode(syms[0]);
            if (!tok[2]) begin
                abort_run({"channel 0 sent no control token during blanking ", where});
            end
            check_bit({"hsync ", where}, tok[0], x >= HS_LO && x < HS_HI);
            check_bit({"vsync ", where}, tok[1], y >= VS_LO && y < VS_HI);
            check_sym({"tmds_ch1 ", where}, tmds_ch1, TOKEN_00);
            check_sym({"tmds_ch2 ", where}, tmds_ch2, TOKEN_00);
            disp = '{0, 0, 0};  // encoders restart the balance in blanking
        end
    endtask

    // every position of frame f, starting at the clock its first pixel reaches the outputs
    task automatic scan_frame(input int f);
        int start;
        start = PIPE_CYC + f * FRAME_CYC;
        while (cycles < start) begin
            @(negedge clk_pix);
        end
        if (cycles != start) begin
            abort_run($sformatf("frame %0d reached the outputs before its check began", f));
        end
        disp = '{0, 0, 0};
        for (int n = 0; n < FRAME_CYC; n++) begin
            if (n > 0) begin
                @(negedge clk_pix);
            end
            verify_pixel(n % LINE_CYC, n / LINE_CYC);
        end
    endtask

    task automatic after_reset();
        repeat (3) @(negedge clk_pix);
        expect_idle("in reset");
        reset = 1'b0;
        repeat (PIPE_CYC - 1) begin  // pipeline still holds reset values
            @(negedge clk_pix);
            expect_idle("after reset");
        end
    endtask

    task automatic load_memories();
        for (int i = 0; i < PAL_DEPTH; i++) begin
            // index in the top bits keeps every entry distinct
            palette_write(canv_pix_t'(i), {4'(i), ~4'(i), 7'($random(seed))});
        end
        for (int a = 0; a < CANV_PIXELS; a++) begin
            canvas_write(canv_addr_t'(a), canv_pix_t'($random(seed)));
        end
    endtask

    task automatic palette_change();
        canv_pix_t idx;
        idx = canv_model[9];  // colour of canvas (1,1), always on screen
        palette_write(idx, pal_model[idx] ^ 15'h5555);
        scan_frame(2);
    endtask

    task automatic canvas_change();
        canvas_write(canv_addr_t'(27), canv_model[27] ^ 4'h5);  // distinct palette colour
        scan_frame(3);
    endtask

    initial begin
        reset = 1'b1;
        canv_we = 1'b0;
        canv_wr_addr = '0;
        canv_wr_pix = '0;
        pal_we = 1'b0;
        pal_wr_addr = '0;
        pal_wr_colr = '0;
        after_reset();
        load_memories();  // done well before frame 0 reaches the window
        scan_frame(1);    // sync, window, background, disparity
        palette_change();
        canvas_change();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== list.f ====
disp_pkg.sv
display_timings.sv
canvas_window.sv
canvas_buffer.sv
colour_stage.sv
tmds_encoder.sv
display_top.sv
tb_display.sv

// ==== Makefile ====
# Verilator build and run of the display pipeline testbench
VERILATOR  ?= verilator
TOP        ?= tb_display
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing -Wall

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
